//--- common/obi_settings.svh
/*
 * OBI memory subsystem sizing
 * Bus widths, memory depth and fetch pipelining limit
 */

`ifndef OBI_SETTINGS_SVH
`define OBI_SETTINGS_SVH

// Byte address width on every OBI bus
`define OBI_ADDR_W 32

// Read and write data width
`define OBI_DATA_W 32

// Byte enable width, one bit per data byte
`define OBI_BE_W (`OBI_DATA_W / 8)

// SRAM depth in words, word addresses at or above this are out of range
`define OBI_RAM_WORDS 1024

// Fetch requests allowed in flight at once
`define OBI_FETCH_MAX_OUT 2

`endif

//--- common/obi_pkg.sv
/*
 * OBI subsystem shared types
 * Source ids for arbitration, LSU opcodes and the fetch FSM states
 */

package obi_pkg;

    // ----------------------------------------------------------------------
    // Bus masters
    // ----------------------------------------------------------------------

    // Owner of a transaction on the shared memory bus
    typedef enum logic {
        SRC_FETCH = 1'b0,
        SRC_LSU   = 1'b1
    } obi_src_e;

    // ----------------------------------------------------------------------
    // Load/store unit
    // ----------------------------------------------------------------------

    // Command opcode, a store drives we high
    typedef enum logic {
        LSU_LOAD  = 1'b0,
        LSU_STORE = 1'b1
    } lsu_op_e;

    // ----------------------------------------------------------------------
    // Instruction fetch
    // ----------------------------------------------------------------------

    // Fetch FSM
    // IDLE waits for fetch enable, RUN issues requests,
    // DRAIN waits for the last responses after enable drops
    typedef enum logic [1:0] {
        FETCH_IDLE  = 2'b00,
        FETCH_RUN   = 2'b01,
        FETCH_DRAIN = 2'b10
    } fetch_state_e;

endpackage : obi_pkg

//--- common/obi_bus_if.sv
/*
 * OBI bus, request and response channels
 * rready is always high in this system and is not carried
 */

`timescale 1ns/1ps

`include "obi_settings.svh"

interface obi_bus_if (
    input logic clk_i
);

    // Request channel, held stable by the master until gnt
    logic                    req;
    logic                    gnt;
    logic [`OBI_ADDR_W-1:0]  addr;
    logic                    we;
    logic [`OBI_BE_W-1:0]    be;
    logic [`OBI_DATA_W-1:0]  wdata;

    // Response channel, one rvalid pulse per granted request
    logic                    rvalid;
    logic [`OBI_DATA_W-1:0]  rdata;
    logic                    err;

    // Requester side
    modport master (
        input  clk_i,
        output req, addr, we, be, wdata,
        input  gnt, rvalid, rdata, err
    );

    // Responder side
    modport slave (
        input  clk_i,
        input  req, addr, we, be, wdata,
        output gnt, rvalid, rdata, err
    );

endinterface : obi_bus_if

//--- fetch/obi_fetch_unit.sv
/*
 * Instruction fetch unit
 * Reads consecutive words over OBI with up to two requests in flight
 */

`timescale 1ns/1ps

`include "obi_settings.svh"

module obi_fetch_unit import obi_pkg::*; (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   fetch_en_i,
    input  logic [`OBI_ADDR_W-1:0] boot_addr_i,
    obi_bus_if.master              bus_m,
    output logic                   instr_valid_o,
    output logic [`OBI_ADDR_W-1:0] instr_addr_o,
    output logic [`OBI_DATA_W-1:0] instr_rdata_o,
    output logic                   instr_err_o
);

    localparam int PTR_W = $clog2(`OBI_FETCH_MAX_OUT);
    localparam int CNT_W = $clog2(`OBI_FETCH_MAX_OUT + 1);
    localparam logic [`OBI_ADDR_W-1:0] PC_STEP = 'd4;

    fetch_state_e            state_q;
    fetch_state_e            state_d;
    logic [`OBI_ADDR_W-1:0]  pc_q;
    logic [CNT_W-1:0]        out_cnt_q;
    logic [`OBI_ADDR_W-1:0]  addr_fifo_q [`OBI_FETCH_MAX_OUT];
    logic [PTR_W-1:0]        wr_ptr_q;
    logic [PTR_W-1:0]        rd_ptr_q;
    logic                    issue;
    logic                    xfer;
    logic                    resp;

    // ----------------------------------------------------------------------
    // OBI request side
    // ----------------------------------------------------------------------

    // Request while running and below the in-flight limit
    assign issue = (state_q == FETCH_RUN) && (out_cnt_q < CNT_W'(`OBI_FETCH_MAX_OUT));
    assign xfer  = bus_m.req && bus_m.gnt;
    assign resp  = bus_m.rvalid;

    assign bus_m.req   = issue;
    assign bus_m.addr  = pc_q;
    // Instruction side only reads full words
    assign bus_m.we    = 1'b0;
    assign bus_m.be    = '1;
    assign bus_m.wdata = '0;

    // ----------------------------------------------------------------------
    // Fetch FSM
    // ----------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            FETCH_IDLE: begin
                if (fetch_en_i) begin
                    state_d = FETCH_RUN;
                end
            end
            FETCH_RUN: begin
                // A request waiting for gnt must stay up, leave only after it
                if (!fetch_en_i && !(issue && !bus_m.gnt)) begin
                    state_d = FETCH_DRAIN;
                end
            end
            FETCH_DRAIN: begin
                if (out_cnt_q == '0) begin
                    state_d = FETCH_IDLE;
                end
            end
            default: begin
                state_d = FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q       <= FETCH_IDLE;
            out_cnt_q     <= '0;
            wr_ptr_q      <= '0;
            rd_ptr_q      <= '0;
            instr_valid_o <= 1'b0;
        end else begin
            state_q <= state_d;
            // Outstanding count, grant in and response out may coincide
            if (xfer && !resp) begin
                out_cnt_q <= out_cnt_q + 1'b1;
            end else if (!xfer && resp) begin
                out_cnt_q <= out_cnt_q - 1'b1;
            end
            if (xfer) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (resp) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            instr_valid_o <= resp;
        end
    end

    // PC, address FIFO and registered instruction outputs
    always_ff @(posedge clk_i) begin
        if ((state_q == FETCH_IDLE) && fetch_en_i) begin
            pc_q <= boot_addr_i;
        end else if (xfer) begin
            pc_q <= pc_q + PC_STEP;
        end
        if (xfer) begin
            addr_fifo_q[wr_ptr_q] <= pc_q;
        end
        // In-order responses pair with the oldest FIFO entry
        if (resp) begin
            instr_addr_o  <= addr_fifo_q[rd_ptr_q];
            instr_rdata_o <= bus_m.rdata;
            instr_err_o   <= bus_m.err;
        end
    end

endmodule : obi_fetch_unit

//--- lsu/obi_lsu.sv
/*
 * Load/store unit
 * Turns one command into one OBI transaction and returns the result
 */

`timescale 1ns/1ps

`include "obi_settings.svh"

module obi_lsu import obi_pkg::*; (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   cmd_valid_i,
    input  lsu_op_e                cmd_op_i,
    input  logic [`OBI_ADDR_W-1:0] cmd_addr_i,
    input  logic [`OBI_BE_W-1:0]   cmd_be_i,
    input  logic [`OBI_DATA_W-1:0] cmd_wdata_i,
    obi_bus_if.master              bus_m,
    output logic                   lsu_busy_o,
    output logic                   lsu_done_o,
    output logic [`OBI_DATA_W-1:0] lsu_rdata_o,
    output logic                   lsu_err_o
);

    // Control state
    logic                    busy_q;
    logic                    req_q;

    // Captured command
    lsu_op_e                 op_q;
    logic [`OBI_ADDR_W-1:0]  addr_q;
    logic [`OBI_BE_W-1:0]    be_q;
    logic [`OBI_DATA_W-1:0]  wdata_q;

    logic                    accept;
    logic                    resp;

    // ----------------------------------------------------------------------
    // Handshake
    // ----------------------------------------------------------------------

    // Strobes while busy are dropped
    assign accept = cmd_valid_i && !busy_q;
    // Response belongs to the granted request
    assign resp   = busy_q && !req_q && bus_m.rvalid;

    assign lsu_busy_o = busy_q;

    // Request fields come straight from the command registers,
    // so they hold still until gnt
    assign bus_m.req   = req_q;
    assign bus_m.addr  = addr_q;
    assign bus_m.we    = (op_q == LSU_STORE);
    assign bus_m.be    = be_q;
    assign bus_m.wdata = wdata_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q     <= 1'b0;
            req_q      <= 1'b0;
            lsu_done_o <= 1'b0;
        end else begin
            lsu_done_o <= resp;
            if (accept) begin
                busy_q <= 1'b1;
                req_q  <= 1'b1;
            end else begin
                // Request phase ends at gnt
                if (req_q && bus_m.gnt) begin
                    req_q <= 1'b0;
                end
                // Response phase ends at rvalid
                if (resp) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Command capture and result
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q    <= cmd_op_i;
            addr_q  <= cmd_addr_i;
            be_q    <= cmd_be_i;
            wdata_q <= cmd_wdata_i;
        end
        if (resp) begin
            // Stores report zero data
            lsu_rdata_o <= (op_q == LSU_LOAD) ? bus_m.rdata : '0;
            lsu_err_o   <= bus_m.err;
        end
    end

endmodule : obi_lsu

//--- src/obi_arbiter.sv
/*
 * Two-master OBI arbiter
 * Round-robin grant onto the memory bus, responses routed back by source
 */

`timescale 1ns/1ps

module obi_arbiter import obi_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    obi_bus_if.slave  fetch_s,
    obi_bus_if.slave  lsu_s,
    obi_bus_if.master mem_m
);

    obi_src_e last_q;
    obi_src_e route_q;
    obi_src_e sel;
    logic     route_vld_q;
    logic     mem_xfer;

    // ----------------------------------------------------------------------
    // Request selection
    // ----------------------------------------------------------------------

    // Contention goes to the source not granted last
    always_comb begin
        if (fetch_s.req && lsu_s.req) begin
            sel = (last_q == SRC_FETCH) ? SRC_LSU : SRC_FETCH;
        end else if (lsu_s.req) begin
            sel = SRC_LSU;
        end else begin
            sel = SRC_FETCH;
        end
    end

    assign mem_m.req = fetch_s.req || lsu_s.req;
    assign mem_xfer  = mem_m.req && mem_m.gnt;

    // Forward the selected request fields
    always_comb begin
        if (sel == SRC_LSU) begin
            mem_m.addr  = lsu_s.addr;
            mem_m.we    = lsu_s.we;
            mem_m.be    = lsu_s.be;
            mem_m.wdata = lsu_s.wdata;
        end else begin
            mem_m.addr  = fetch_s.addr;
            mem_m.we    = fetch_s.we;
            mem_m.be    = fetch_s.be;
            mem_m.wdata = fetch_s.wdata;
        end
    end

    // Loser sees gnt low and keeps its request up
    assign fetch_s.gnt = mem_m.gnt && fetch_s.req && (sel == SRC_FETCH);
    assign lsu_s.gnt   = mem_m.gnt && lsu_s.req && (sel == SRC_LSU);

    // ----------------------------------------------------------------------
    // Response routing
    // ----------------------------------------------------------------------

    // Memory answers one cycle after a transfer, one route entry is enough
    assign fetch_s.rvalid = mem_m.rvalid && route_vld_q && (route_q == SRC_FETCH);
    assign lsu_s.rvalid   = mem_m.rvalid && route_vld_q && (route_q == SRC_LSU);

    // Data and error are only looked at with rvalid
    assign fetch_s.rdata = mem_m.rdata;
    assign fetch_s.err   = mem_m.err;
    assign lsu_s.rdata   = mem_m.rdata;
    assign lsu_s.err     = mem_m.err;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // Fetch wins the first contention
            last_q      <= SRC_LSU;
            route_q     <= SRC_FETCH;
            route_vld_q <= 1'b0;
        end else begin
            route_q     <= sel;
            route_vld_q <= mem_xfer;
            if (mem_xfer) begin
                last_q <= sel;
            end
        end
    end

endmodule : obi_arbiter

//--- src/obi_sram.sv
/*
 * Word-addressed OBI SRAM slave
 * Byte-enable writes, range check, response one cycle after the transfer
 */

`timescale 1ns/1ps

`include "obi_settings.svh"

module obi_sram (
    input  logic     clk_i,
    input  logic     reset_i,
    obi_bus_if.slave bus_s
);

    localparam int IDX_W = $clog2(`OBI_RAM_WORDS);

    logic [`OBI_DATA_W-1:0]  mem [`OBI_RAM_WORDS];
    logic [`OBI_ADDR_W-3:0]  word_addr;
    logic [IDX_W-1:0]        idx;
    logic                    in_range;
    logic                    xfer;

    // Always ready, so a new request every cycle
    assign bus_s.gnt = bus_s.req;
    assign xfer      = bus_s.req && bus_s.gnt;

    // Byte address to word index
    assign word_addr = bus_s.addr[`OBI_ADDR_W-1:2];
    assign in_range  = (word_addr < `OBI_RAM_WORDS);
    assign idx       = word_addr[IDX_W-1:0];

    // ----------------------------------------------------------------------
    // Storage and read data
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (xfer && bus_s.we && in_range) begin
            // Only enabled bytes change
            for (int b = 0; b < `OBI_BE_W; b++) begin
                if (bus_s.be[b]) begin
                    mem[idx][8*b +: 8] <= bus_s.wdata[8*b +: 8];
                end
            end
        end
        if (xfer) begin
            // Out of range reads back zero with err
            bus_s.rdata <= (in_range && !bus_s.we) ? mem[idx] : '0;
            bus_s.err   <= !in_range;
        end
    end

    // Response strobe
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            bus_s.rvalid <= 1'b0;
        end else begin
            bus_s.rvalid <= xfer;
        end
    end

endmodule : obi_sram

//--- src/obi_subsys_top.sv
/*
 * OBI memory subsystem top
 * Fetch unit and LSU share one SRAM through a round-robin arbiter
 */

`timescale 1ns/1ps

`include "obi_settings.svh"

module obi_subsys_top import obi_pkg::*; (
    input  logic                   clk_i,
    input  logic                   reset_i,

    // Instruction fetch control and results
    input  logic                   fetch_en_i,
    input  logic [`OBI_ADDR_W-1:0] boot_addr_i,
    output logic                   instr_valid_o,
    output logic [`OBI_ADDR_W-1:0] instr_addr_o,
    output logic [`OBI_DATA_W-1:0] instr_rdata_o,
    output logic                   instr_err_o,

    // Load/store commands and results
    input  logic                   cmd_valid_i,
    input  lsu_op_e                cmd_op_i,
    input  logic [`OBI_ADDR_W-1:0] cmd_addr_i,
    input  logic [`OBI_BE_W-1:0]   cmd_be_i,
    input  logic [`OBI_DATA_W-1:0] cmd_wdata_i,
    output logic                   lsu_busy_o,
    output logic                   lsu_done_o,
    output logic [`OBI_DATA_W-1:0] lsu_rdata_o,
    output logic                   lsu_err_o
);

    // ----------------------------------------------------------------------
    // Buses
    // ----------------------------------------------------------------------

    // Instruction master to arbiter
    obi_bus_if fetch_bus (.clk_i(clk_i));
    // Data master to arbiter
    obi_bus_if lsu_bus (.clk_i(clk_i));
    // Arbiter to SRAM
    obi_bus_if mem_bus (.clk_i(clk_i));

    // ----------------------------------------------------------------------
    // Masters
    // ----------------------------------------------------------------------

    obi_fetch_unit fetch_unit_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .fetch_en_i    (fetch_en_i),
        .boot_addr_i   (boot_addr_i),
        .bus_m         (fetch_bus),
        .instr_valid_o (instr_valid_o),
        .instr_addr_o  (instr_addr_o),
        .instr_rdata_o (instr_rdata_o),
        .instr_err_o   (instr_err_o)
    );

    obi_lsu lsu_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_op_i    (cmd_op_i),
        .cmd_addr_i  (cmd_addr_i),
        .cmd_be_i    (cmd_be_i),
        .cmd_wdata_i (cmd_wdata_i),
        .bus_m       (lsu_bus),
        .lsu_busy_o  (lsu_busy_o),
        .lsu_done_o  (lsu_done_o),
        .lsu_rdata_o (lsu_rdata_o),
        .lsu_err_o   (lsu_err_o)
    );

    // ----------------------------------------------------------------------
    // Interconnect and memory
    // ----------------------------------------------------------------------

    obi_arbiter arbiter_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .fetch_s (fetch_bus),
        .lsu_s   (lsu_bus),
        .mem_m   (mem_bus)
    );

    obi_sram sram_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .bus_s   (mem_bus)
    );

endmodule : obi_subsys_top

//--- tests/obi_subsys_props.sv
/*
 * OBI master-side protocol assertions
 * Bound to the fetch unit and the LSU
 */

`timescale 1ns/1ps

`include "obi_settings.svh"

module obi_subsys_props (
    input logic                                               clk_i,
    input logic                                               reset_i,
    input logic                                               req_i,
    input logic                                               gnt_i,
    input logic [`OBI_ADDR_W+`OBI_BE_W+`OBI_DATA_W:0]         fields_i,
    input logic                                               rvalid_i,
    input logic                                               done_i,
    input logic                                               busy_i
);

    // Assertion failure count, read by the testbench at the end
    int fail_cnt = 0;
    // Granted requests still waiting for their response
    int out_cnt;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_cnt <= 0;
        end else begin
            out_cnt <= out_cnt + int'(req_i && gnt_i) - int'(rvalid_i);
        end
    end

    // Request and its fields hold until the grant
    a_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        req_i && !gnt_i |=> req_i && $stable(fields_i))
        else begin
            fail_cnt++;
            $error("request dropped or changed before grant");
        end

    // Response only for a granted request
    a_rvalid_out: assert property (@(posedge clk_i) disable iff (reset_i)
        rvalid_i |-> out_cnt != 0)
        else begin
            fail_cnt++;
            $error("rvalid with no request outstanding");
        end

    // Done closes a busy period
    a_done_busy: assert property (@(posedge clk_i) disable iff (reset_i)
        done_i |-> $past(busy_i))
        else begin
            fail_cnt++;
            $error("done without busy in the previous cycle");
        end

endmodule : obi_subsys_props

// Fetch has no done or busy, those rules stay idle there
bind obi_fetch_unit obi_subsys_props props_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (bus_m.req),
    .gnt_i    (bus_m.gnt),
    .fields_i ({bus_m.addr, bus_m.we, bus_m.be, bus_m.wdata}),
    .rvalid_i (bus_m.rvalid),
    .done_i   (1'b0),
    .busy_i   (1'b0)
);

bind obi_lsu obi_subsys_props props_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (bus_m.req),
    .gnt_i    (bus_m.gnt),
    .fields_i ({bus_m.addr, bus_m.we, bus_m.be, bus_m.wdata}),
    .rvalid_i (bus_m.rvalid),
    .done_i   (lsu_done_o),
    .busy_i   (lsu_busy_o)
);

//--- tests/obi_subsys_tb.sv
/*
 * Directed testbench for the OBI memory subsystem
 * LSU and fetch traffic checked against a reference memory
 */

`timescale 1ns/1ps

`include "obi_settings.svh"

module obi_subsys_tb import obi_pkg::*; ();

    localparam logic [31:0] SEED = 32'h5a71_df28;
    localparam int N_RAND       = 16;
    localparam int N_FETCH      = 12;
    localparam int N_MIX        = 4;
    localparam int DRAIN_CYCLES = 8;
    // Rough transaction count over all tests including the memory preload
    localparam int TOTAL_TXN = `OBI_RAM_WORDS + 3*N_RAND + 16 + 4*N_FETCH + 20*N_MIX;
    localparam int WATCHDOG_CYCLES = TOTAL_TXN * 20;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    fetch_en;
    logic [`OBI_ADDR_W-1:0]  boot_addr;
    logic                    instr_valid;
    logic [`OBI_ADDR_W-1:0]  instr_addr;
    logic [`OBI_DATA_W-1:0]  instr_rdata;
    logic                    instr_err;
    logic                    cmd_valid;
    lsu_op_e                 cmd_op;
    logic [`OBI_ADDR_W-1:0]  cmd_addr;
    logic [`OBI_BE_W-1:0]    cmd_be;
    logic [`OBI_DATA_W-1:0]  cmd_wdata;
    logic                    lsu_busy;
    logic                    lsu_done;
    logic [`OBI_DATA_W-1:0]  lsu_rdata;
    logic                    lsu_err;

    // Reference memory and captured fetch stream
    logic [31:0] ref_mem [`OBI_RAM_WORDS];
    logic [31:0] fetch_addr_q [$];
    logic [31:0] fetch_data_q [$];
    logic        fetch_err_q [$];

    int err_cnt    = 0;
    int check_cnt  = 0;
    int test_cnt   = 0;
    int fail_tests = 0;
    int done_cnt   = 0;

    obi_subsys_top obi_subsys_top_i (
        .clk_i         (clk),
        .reset_i       (reset),
        .fetch_en_i    (fetch_en),
        .boot_addr_i   (boot_addr),
        .instr_valid_o (instr_valid),
        .instr_addr_o  (instr_addr),
        .instr_rdata_o (instr_rdata),
        .instr_err_o   (instr_err),
        .cmd_valid_i   (cmd_valid),
        .cmd_op_i      (cmd_op),
        .cmd_addr_i    (cmd_addr),
        .cmd_be_i      (cmd_be),
        .cmd_wdata_i   (cmd_wdata),
        .lsu_busy_o    (lsu_busy),
        .lsu_done_o    (lsu_done),
        .lsu_rdata_o   (lsu_rdata),
        .lsu_err_o     (lsu_err)
    );

    always #2 clk = ~clk;

    // Registered outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (instr_valid) begin
            fetch_addr_q.push_back(instr_addr);
            fetch_data_q.push_back(instr_rdata);
            fetch_err_q.push_back(instr_err);
        end
        if (lsu_done) begin
            done_cnt++;
        end
    end

    // ----------------------------------------------------------------------
    // Checking and reference model
    // ----------------------------------------------------------------------

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    function automatic logic in_range(input logic [31:0] addr);
        return (addr >> 2) < `OBI_RAM_WORDS;
    endfunction

    // Out of range reads as zero
    function automatic logic [31:0] ref_load(input logic [31:0] addr);
        return in_range(addr) ? ref_mem[addr[11:2]] : 32'h0;
    endfunction

    // Byte-enable merge that drops out of range stores
    task automatic ref_store(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
        if (in_range(addr)) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    ref_mem[addr[11:2]][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
    endtask

    // Preload pattern that depends on every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], ~addr[15:0]} ^ {addr[31:16], addr[31:16]} ^ 32'h6b1d_42e7;
    endfunction

    // ----------------------------------------------------------------------
    // LSU and fetch drivers
    // ----------------------------------------------------------------------

    task automatic lsu_command(input lsu_op_e op, input logic [31:0] addr,
                               input logic [3:0] be, input logic [31:0] wdata,
                               output logic [31:0] rdata, output logic err);
        while (lsu_busy) @(negedge clk);
        @(posedge clk);
        #1;
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_be    = be;
        cmd_wdata = wdata;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        do @(negedge clk); while (!lsu_done);
        rdata = lsu_rdata;
        err   = lsu_err;
        if (op == LSU_STORE) begin
            ref_store(addr, be, wdata);
        end
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        lsu_command(LSU_STORE, addr, be, data, rdata, err);
        check_val("lsu_rdata_o", rdata, 32'h0);
        check_val("lsu_err_o", err, !in_range(addr));
    endtask

    task automatic load_check(input logic [31:0] addr);
        logic [31:0] rdata;
        logic        err;
        lsu_command(LSU_LOAD, addr, 4'hf, 32'h0, rdata, err);
        check_val("lsu_rdata_o", rdata, ref_load(addr));
        check_val("lsu_err_o", err, !in_range(addr));
    endtask

    task automatic start_fetch(input logic [31:0] addr);
        @(posedge clk);
        #1;
        fetch_addr_q.delete();
        fetch_data_q.delete();
        fetch_err_q.delete();
        boot_addr = addr;
        fetch_en  = 1'b1;
    endtask

    // Base counts pulses seen before the DUT sampled the drop
    task automatic stop_fetch(output int base);
        @(posedge clk);
        #1;
        fetch_en = 1'b0;
        @(posedge clk);
        #1;
        base = fetch_addr_q.size();
        // Responses land a fixed number of cycles after the last request
        repeat (DRAIN_CYCLES) @(posedge clk);
    endtask

    task automatic wait_fetch_count(input int n);
        while (fetch_addr_q.size() < n) @(negedge clk);
    endtask

    // Consecutive words from start with no gap and no repeat
    task automatic check_fetch_stream(input logic [31:0] start);
        logic [31:0] exp_addr;
        for (int i = 0; i < fetch_addr_q.size(); i++) begin
            exp_addr = start + 32'(4*i);
            check_val("instr_addr_o", fetch_addr_q[i], exp_addr);
            check_val("instr_rdata_o", fetch_data_q[i], ref_load(exp_addr));
            check_val("instr_err_o", fetch_err_q[i], !in_range(exp_addr));
        end
    endtask

    task automatic preload_memory();
        for (int w = 0; w < `OBI_RAM_WORDS; w++) begin
            store_word(32'(w) << 2, 4'hf, fill_word(32'(w) << 2));
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        test_cnt++;
        if (err_cnt == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            fail_tests++;
            $display("test %s: %0d errors", name, err_cnt - errs_at_start);
        end
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------

    task automatic test_reset_idle();
        int first_err;
        first_err = err_cnt;
        repeat (10) begin
            @(negedge clk);
            check_val("instr_valid_o", instr_valid, 1'b0);
            check_val("lsu_done_o", lsu_done, 1'b0);
            check_val("lsu_busy_o", lsu_busy, 1'b0);
        end
        finish_test("reset_idle", first_err);
    endtask

    task automatic test_store_load();
        logic [31:0] addr [N_RAND];
        int          first_err;
        int          done_before;
        first_err = err_cnt;
        for (int i = 0; i < N_RAND; i++) begin
            addr[i] = $urandom_range(`OBI_RAM_WORDS - 1) << 2;
            store_word(addr[i], 4'($urandom), $urandom);
        end
        for (int i = 0; i < N_RAND; i++) begin
            load_check(addr[i]);
        end
        // Second strobe lands while the load is busy and must be dropped
        @(posedge clk);
        #1;
        done_before = done_cnt;
        cmd_valid = 1'b1;
        cmd_op    = LSU_LOAD;
        cmd_addr  = addr[0];
        cmd_be    = 4'hf;
        @(posedge clk);
        #1;
        check_val("lsu_busy_o", lsu_busy, 1'b1);
        cmd_op    = LSU_STORE;
        cmd_addr  = addr[1];
        cmd_wdata = ~ref_load(addr[1]);
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        do @(negedge clk); while (!lsu_done);
        check_val("lsu_rdata_o", lsu_rdata, ref_load(addr[0]));
        repeat (4) @(negedge clk);
        check_val("lsu_done_o count", done_cnt - done_before, 1);
        load_check(addr[1]);
        finish_test("store_load", first_err);
    endtask

    task automatic test_seq_fetch();
        int first_err;
        int base;
        first_err = err_cnt;
        start_fetch(32'h0000_0400);
        wait_fetch_count(N_FETCH);
        stop_fetch(base);
        check_fetch_stream(32'h0000_0400);
        finish_test("seq_fetch", first_err);
    endtask

    task automatic test_concurrent();
        int first_err;
        int base;
        first_err = err_cnt;
        start_fetch(32'h0000_0440);
        // Data words well below the fetch window
        for (int i = 0; i < N_MIX; i++) begin
            store_word(32'h80 + 32'(4*i), 4'($urandom), $urandom);
        end
        for (int i = 0; i < N_MIX; i++) begin
            load_check(32'h80 + 32'(4*i));
        end
        stop_fetch(base);
        check_val("fetch progress", fetch_addr_q.size() >= 2*N_MIX, 1'b1);
        check_fetch_stream(32'h0000_0440);
        finish_test("concurrent", first_err);
    endtask

    task automatic test_out_of_range();
        int first_err;
        int base;
        first_err = err_cnt;
        load_check(32'h0000_1000);
        load_check(32'h8000_0004);
        // Would alias word 0 if the range check were missing
        store_word(32'h0000_1000, 4'hf, 32'hdead_beef);
        load_check(32'h0000_0000);
        // Last two words and then two past the end
        start_fetch(32'h0000_0ff8);
        wait_fetch_count(4);
        stop_fetch(base);
        check_fetch_stream(32'h0000_0ff8);
        finish_test("out_of_range", first_err);
    endtask

    task automatic test_stop_restart();
        int first_err;
        int base;
        first_err = err_cnt;
        start_fetch(32'h0000_0400);
        wait_fetch_count(6);
        stop_fetch(base);
        check_val("instr_valid_o after stop within limit",
                  (fetch_addr_q.size() - base) <= `OBI_FETCH_MAX_OUT, 1'b1);
        check_fetch_stream(32'h0000_0400);
        start_fetch(32'h0000_0480);
        wait_fetch_count(N_FETCH);
        stop_fetch(base);
        check_fetch_stream(32'h0000_0480);
        finish_test("stop_restart", first_err);
    endtask

    // ----------------------------------------------------------------------
    // Sequence and watchdog
    // ----------------------------------------------------------------------

    initial begin
        int prop_fails;
        void'($urandom(SEED));
        reset     = 1'b1;
        fetch_en  = 1'b0;
        boot_addr = '0;
        cmd_valid = 1'b0;
        cmd_op    = LSU_LOAD;
        cmd_addr  = '0;
        cmd_be    = '0;
        cmd_wdata = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_idle();
        preload_memory();
        test_store_load();
        test_seq_fetch();
        test_concurrent();
        test_out_of_range();
        test_stop_restart();
        prop_fails = obi_subsys_top_i.fetch_unit_i.props_i.fail_cnt
                   + obi_subsys_top_i.lsu_i.props_i.fail_cnt;
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_cnt, fail_tests, check_cnt, err_cnt, prop_fails);
        if (err_cnt == 0 && fail_tests == 0 && prop_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule : obi_subsys_tb

//--- project.f
+incdir+common
common/obi_pkg.sv
common/obi_bus_if.sv
fetch/obi_fetch_unit.sv
lsu/obi_lsu.sv
src/obi_arbiter.sv
src/obi_sram.sv
src/obi_subsys_top.sv
tests/obi_subsys_props.sv
tests/obi_subsys_tb.sv

//--- Makefile
TOP := obi_subsys_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
